// File: design/spu_type_pkg.sv
package spu_type_pkg;

    localparam int OPERAND_BITS = 8;
    localparam int PRODUCT_BITS = 2 * OPERAND_BITS;   // full signed product
    localparam int ADDEND_BITS  = 16;
    localparam int RESULT_BITS  = 16;

    // multiplier operand
    typedef logic signed [OPERAND_BITS-1:0] operand_t;

    // product after the multiplier, shifted or not
    typedef logic signed [PRODUCT_BITS-1:0] product_t;

    // addend c, carried beside the multiplier
    typedef logic signed [ADDEND_BITS-1:0]  addend_t;

    // lane output
    typedef logic signed [RESULT_BITS-1:0]  result_t;

    // saturation limits of the lane output
    localparam result_t RESULT_MAX = {1'b0, {(RESULT_BITS - 1){1'b1}}};
    localparam result_t RESULT_MIN = {1'b1, {(RESULT_BITS - 1){1'b0}}};

endpackage

// File: design/spu_cfg_pkg.sv
package spu_cfg_pkg;

    // enabled cycles from multiplier inputs to multiplier output
    localparam int MUL_LATENCY = 3;

    // adder register stage
    localparam int ADD_LATENCY = 1;

    // whole lane, inputs to m_data
    localparam int LANE_LATENCY = MUL_LATENCY + ADD_LATENCY;

    // arithmetic right shift on the product before the add
    localparam int PRODUCT_SHIFT = 2;

    // stored when clear and valid are both set
    localparam int CLEAR_VALUE = 0;

endpackage

// File: design/spu_op_nop.sv
module spu_op_nop #(
    parameter int LATENCY   = 1,
    parameter int DATA_BITS = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cke,
    input  logic [DATA_BITS-1:0] s_data,
    input  logic                 s_clear,
    input  logic                 s_valid,
    output logic [DATA_BITS-1:0] m_data
);
    import spu_cfg_pkg::*;

    if (LATENCY == 0) begin : g_wire
        assign m_data = s_data;
    end else begin : g_delay
        logic [DATA_BITS-1:0] pre_data;    // feeds the final stage
        logic                 pre_clear;
        logic                 pre_valid;

        if (LATENCY == 1) begin : g_direct
            assign pre_data  = s_data;
            assign pre_clear = s_clear;
            assign pre_valid = s_valid;
        end else begin : g_shift
            logic [DATA_BITS-1:0] sr_data [LATENCY-1];
            logic [LATENCY-2:0]   sr_clear;
            logic [LATENCY-2:0]   sr_valid;

            always_ff @(posedge clk) begin
                if (reset) begin
                    sr_clear <= '0;
                    sr_valid <= '0;
                end else if (cke) begin
                    for (int i = LATENCY - 2; i > 0; i--) begin
                        sr_clear[i] <= sr_clear[i-1];
                        sr_valid[i] <= sr_valid[i-1];
                    end
                    sr_clear[0] <= s_clear;
                    sr_valid[0] <= s_valid;
                end
            end

            always_ff @(posedge clk) begin
                if (cke) begin
                    for (int i = LATENCY - 2; i > 0; i--) begin
                        sr_data[i] <= sr_data[i-1];
                    end
                    sr_data[0] <= s_data;
                end
            end

            assign pre_data  = sr_data[LATENCY-2];
            assign pre_clear = sr_clear[LATENCY-2];
            assign pre_valid = sr_valid[LATENCY-2];
        end

        // final stage holds on invalid
        always_ff @(posedge clk) begin
            if (reset) begin
                m_data <= '0;
            end else if (cke && pre_valid) begin
                m_data <= pre_clear ? DATA_BITS'(CLEAR_VALUE) : pre_data;
            end
        end
    end

endmodule

// File: design/spu_op_mul.sv
module spu_op_mul #(
    parameter int LATENCY    = 3,
    parameter int DATA_SHIFT = 0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cke,
    input  spu_type_pkg::operand_t s_data0,
    input  spu_type_pkg::operand_t s_data1,
    input  logic                   s_clear,
    input  logic                   s_valid,
    output spu_type_pkg::product_t m_data
);
    import spu_type_pkg::*;
    import spu_cfg_pkg::*;

    if (LATENCY < 3) begin : g_comb_mul
        product_t st0_data;

        assign st0_data = (product_t'(s_data0) * product_t'(s_data1)) >>> DATA_SHIFT;

        spu_op_nop #(
            .LATENCY   (LATENCY),
            .DATA_BITS ($bits(product_t))
        ) u_delay (
            .clk     (clk),
            .reset   (reset),
            .cke     (cke),
            .s_data  (st0_data),
            .s_clear (s_clear),
            .s_valid (s_valid),
            .m_data  (m_data)
        );
    end else begin : g_pipe_mul
        operand_t st0_data0;
        operand_t st0_data1;
        logic     st0_clear;
        logic     st0_valid;
        product_t st1_data;
        logic     st1_clear;
        logic     st1_valid;
        product_t st2_data;
        logic     st2_valid;

        always_ff @(posedge clk) begin
            if (reset) begin
                st0_clear <= 1'b0;
                st0_valid <= 1'b0;
                st1_clear <= 1'b0;
                st1_valid <= 1'b0;
                st2_data  <= '0;
                st2_valid <= 1'b0;
            end else if (cke) begin
                st0_clear <= s_clear;
                st0_valid <= s_valid;
                st1_clear <= st0_clear;
                st1_valid <= st0_valid;
                if (st1_valid) begin                  // hold last result otherwise
                    st2_data <= st1_clear ? product_t'(CLEAR_VALUE) : st1_data;
                end
                st2_valid <= st1_valid;
            end
        end

        always_ff @(posedge clk) begin
            if (cke) begin
                st0_data0 <= s_data0;
                st0_data1 <= s_data1;
                st1_data  <= (product_t'(st0_data0) * product_t'(st0_data1)) >>> DATA_SHIFT;
            end
        end

        // extra latency past the third stage
        spu_op_nop #(
            .LATENCY   (LATENCY - 3),
            .DATA_BITS ($bits(product_t))
        ) u_delay (
            .clk     (clk),
            .reset   (reset),
            .cke     (cke),
            .s_data  (st2_data),
            .s_clear (1'b0),
            .s_valid (st2_valid),
            .m_data  (m_data)
        );
    end

endmodule

// File: design/spu_op_add_sat.sv
module spu_op_add_sat (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cke,
    input  spu_type_pkg::product_t product,
    input  spu_type_pkg::addend_t  addend,
    output spu_type_pkg::result_t  m_data
);
    import spu_type_pkg::*;

    logic signed [RESULT_BITS:0] sum;   // one guard bit
    result_t                     sat_sum;

    assign sum = {product[PRODUCT_BITS-1], product} + {addend[ADDEND_BITS-1], addend};

    // guard and sign bits disagree on overflow
    always_comb begin
        if (sum[RESULT_BITS] != sum[RESULT_BITS-1]) begin
            sat_sum = sum[RESULT_BITS] ? RESULT_MIN : RESULT_MAX;
        end else begin
            sat_sum = result_t'(sum);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m_data <= '0;
        end else if (cke) begin
            m_data <= sat_sum;
        end
    end

endmodule

// File: design/spu_mac_lane.sv
module spu_mac_lane (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cke,
    input  spu_type_pkg::operand_t s_a,
    input  spu_type_pkg::operand_t s_b,
    input  spu_type_pkg::addend_t  s_c,
    input  logic                   s_clear,
    input  logic                   s_valid,
    output spu_type_pkg::result_t  m_data
);
    import spu_type_pkg::*;
    import spu_cfg_pkg::*;

    product_t mul_data;      // shifted product
    addend_t  addend_data;   // c aligned to the product

    spu_op_mul #(
        .LATENCY    (MUL_LATENCY),
        .DATA_SHIFT (PRODUCT_SHIFT)
    ) u_mul (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .s_data0 (s_a),
        .s_data1 (s_b),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (mul_data)
    );

    spu_op_nop #(
        .LATENCY   (MUL_LATENCY),
        .DATA_BITS (ADDEND_BITS)
    ) u_addend_delay (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .s_data  (s_c),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (addend_data)
    );

    spu_op_add_sat u_add_sat (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .product (mul_data),
        .addend  (addend_data),
        .m_data  (m_data)
    );

endmodule

// File: tests/spu_mac_lane_props.sv
module spu_mac_lane_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  cke,
    input logic                  s_clear,
    input logic                  s_valid,
    input spu_type_pkg::result_t m_data
);
    import spu_cfg_pkg::*;

    logic [LANE_LATENCY-1:0] clear_track;    // valid clears in flight

    always_ff @(posedge clk) begin
        if (reset) begin
            clear_track <= '0;
        end else if (cke) begin
            clear_track <= {clear_track[LANE_LATENCY-2:0], s_valid && s_clear};
        end
    end

    reset_zeroes_output: assert property (@(posedge clk) reset |=> m_data == '0)
        else $error("m_data is not zero after reset");

    stall_holds_output: assert property (@(posedge clk) disable iff (reset)
        !cke |=> $stable(m_data))
        else $error("m_data changed while cke was low");

    clear_gives_zero: assert property (@(posedge clk) disable iff (reset)
        clear_track[LANE_LATENCY-1] |-> m_data == '0)
        else $error("cleared input did not give zero at m_data");

endmodule

bind spu_mac_lane spu_mac_lane_props u_props (
    .clk     (clk),
    .reset   (reset),
    .cke     (cke),
    .s_clear (s_clear),
    .s_valid (s_valid),
    .m_data  (m_data)
);

// File: tests/spu_mac_lane_tb.sv
module spu_mac_lane_tb;
    import spu_type_pkg::*;
    import spu_cfg_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int N_IDLE     = 8;
    localparam int N_RANDOM   = 200;
    localparam int N_HOLD     = 200;
    localparam int N_CLEAR    = 120;
    localparam int N_SAT      = 16;
    localparam int N_STALL    = 200;
    localparam int N_DRAIN    = LANE_LATENCY + 2;
    localparam int TOTAL_CYCLES = N_IDLE + N_RANDOM + N_HOLD + N_CLEAR + N_SAT + N_STALL + N_DRAIN;
    localparam int TIMEOUT    = (TOTAL_CYCLES + LANE_LATENCY) * 4 * CLK_PERIOD;

    logic     clk;
    logic     reset;
    logic     cke;
    operand_t s_a;
    operand_t s_b;
    addend_t  s_c;
    logic     s_clear;
    logic     s_valid;
    result_t  m_data;

    int       seed;
    int       error_count;
    string    test_name;
    result_t  expected_data;    // model of m_data

    // one entry per enabled edge still in flight
    logic     ring_valid [LANE_LATENCY];
    logic     ring_clear [LANE_LATENCY];
    result_t  ring_value [LANE_LATENCY];
    int       ring_ptr;

    spu_mac_lane DUT (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .s_a     (s_a),
        .s_b     (s_b),
        .s_c     (s_c),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (m_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // sat16(((a * b) >>> shift) + c)
    function automatic result_t mac_reference(input int a, input int b, input int c);
        int prod;
        int sum;
        prod = (a * b) >>> PRODUCT_SHIFT;
        sum  = prod + c;
        if (sum > 32767) begin
            sum = 32767;
        end else if (sum < -32768) begin
            sum = -32768;
        end
        return result_t'(sum);
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            error_count++;
            $display("CHECK FAILED: %s expected %0d actual %0d", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic update_model();
        ring_valid[ring_ptr] = s_valid;
        ring_clear[ring_ptr] = s_clear;
        ring_value[ring_ptr] = mac_reference(int'(s_a), int'(s_b), int'(s_c));
        ring_ptr = (ring_ptr + 1) % LANE_LATENCY;    // now the oldest entry
        if (ring_valid[ring_ptr]) begin
            expected_data = ring_clear[ring_ptr] ? '0 : ring_value[ring_ptr];
        end
    endtask

    task automatic apply_cycle(input logic en, input logic valid, input logic clear,
                               input operand_t a, input operand_t b, input addend_t c);
        @(negedge clk);
        reset   = 1'b0;
        cke     = en;
        s_valid = valid;
        s_clear = clear;
        s_a     = a;
        s_b     = b;
        s_c     = c;
        @(posedge clk);
        if (cke) begin
            update_model();
        end
    endtask

    task automatic drive_random(input logic en, input logic valid, input logic clear);
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = $random(seed);
        r1 = $random(seed);
        apply_cycle(en, valid, clear, operand_t'(r0[7:0]), operand_t'(r0[15:8]),
                    addend_t'(r1[15:0]));
    endtask

    initial begin : watchdog
        #(TIMEOUT);
        $display("watchdog timeout: the lane test did not finish in time");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin : compare_outputs
        wait (reset === 1'b0);
        forever begin
            @(posedge clk);
            #1;    // after the register update
            check_value(test_name, int'(expected_data), int'(m_data));
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        int          slot;
        seed          = 32'h7460_a7a1;
        error_count   = 0;
        expected_data = '0;
        ring_ptr      = 0;
        for (int i = 0; i < LANE_LATENCY; i++) begin
            ring_valid[i] = 1'b0;
            ring_clear[i] = 1'b0;
            ring_value[i] = '0;
        end
        reset   = 1'b1;
        cke     = 1'b1;
        s_a     = '0;
        s_b     = '0;
        s_c     = '0;
        s_clear = 1'b0;
        s_valid = 1'b0;
        test_name = "reset";
        repeat (2) @(posedge clk);

        repeat (N_IDLE) drive_random(1'b1, 1'b0, 1'b0);

        test_name = "random stream";
        repeat (N_RANDOM) drive_random(1'b1, 1'b1, 1'b0);

        test_name = "hold on invalid";
        repeat (N_HOLD) begin
            r = $random(seed);
            drive_random(1'b1, r[0], 1'b0);
        end

        test_name = "clear";
        repeat (N_CLEAR) begin
            r = $random(seed);
            drive_random(1'b1, r[0] | r[1], r[3:2] == 2'b00);
        end

        test_name = "saturation";
        for (int i = 0; i < N_SAT; i++) begin
            case (i % 4)
                0: apply_cycle(1'b1, 1'b1, 1'b0, operand_t'(127), operand_t'(127),
                               addend_t'(32767));
                1: apply_cycle(1'b1, 1'b1, 1'b0, operand_t'(-128), operand_t'(127),
                               addend_t'(-32768));
                2: apply_cycle(1'b1, 1'b1, 1'b0, operand_t'(-128), operand_t'(-128),
                               addend_t'(32767));
                default: apply_cycle(1'b1, 1'b1, 1'b0, operand_t'(127), operand_t'(-128),
                                     addend_t'(100));
            endcase
            #1;
            slot = i - (LANE_LATENCY - 1);    // input now at m_data
            if (slot >= 0 && slot % 4 == 0) begin
                check_value("saturation high", 32767, int'(m_data));
            end else if (slot >= 0 && slot % 4 == 1) begin
                check_value("saturation low", -32768, int'(m_data));
            end
        end

        test_name = "stall";
        repeat (N_STALL) begin
            r = $random(seed);
            drive_random(r[2:0] > 3'd1, r[3] | r[4], r[7:5] == 3'b000);    // cke low 1 in 4
        end

        test_name = "drain";
        repeat (N_DRAIN) drive_random(1'b1, 1'b0, 1'b0);

        @(negedge clk);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: src.f
design/spu_type_pkg.sv
design/spu_cfg_pkg.sv
design/spu_op_nop.sv
design/spu_op_mul.sv
design/spu_op_add_sat.sv
design/spu_mac_lane.sv
tests/spu_mac_lane_props.sv
tests/spu_mac_lane_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module spu_mac_lane_tb -f src.f -o sim_lane \
    && ./obj_dir/sim_lane > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
